// File: src/queue_regs_pkg.sv
// assumes at most one stored and one removed event per queue per cycle, packets up to 4095 bytes
package queue_regs_pkg;

   // ----------------------------------------
   // widths
   // ----------------------------------------
   localparam int data_width        = 32;
   localparam int reg_addr_width    = 8;
   localparam int num_regs          = 11;
   localparam int ram_addr_width    = 4;
   localparam int num_stats         = 5;

   // deltas only need to hold one sweep worth of events
   localparam int word_delta_width  = 14;
   localparam int byte_delta_width  = 16;
   localparam int count_delta_width = 8;
   // two's complement level change
   localparam int level_delta_width = 8;

   // per-packet counts from the queues
   localparam int word_cnt_width    = 10;
   localparam int byte_cnt_width    = 12;

   // ----------------------------------------
   // register map
   // ----------------------------------------
   localparam int ctrl_addr         = 0;
   localparam int rx_base           = 1;
   localparam int tx_base           = 6;

   // offsets within a queue block
   localparam int stat_ofs_enqueued = 0;
   localparam int stat_ofs_dequeued = 1;
   localparam int stat_ofs_words    = 2;
   localparam int stat_ofs_bytes    = 3;
   localparam int stat_ofs_level    = 4;

   // control register bits
   localparam int rx_disable_bit    = 0;
   localparam int tx_disable_bit    = 1;

   localparam logic [data_width-1:0] bad_addr_data = 32'hdead_beef;

   // ----------------------------------------
   // types
   // ----------------------------------------
   typedef struct packed {
      logic                      stored;
      logic                      removed;
      logic [word_cnt_width-1:0] word_cnt;
      logic [byte_cnt_width-1:0] byte_cnt;
   } queue_event_t;

   typedef struct packed {
      logic [count_delta_width-1:0] enqueued;
      logic [count_delta_width-1:0] dequeued;
      logic [word_delta_width-1:0]  words;
      logic [byte_delta_width-1:0]  bytes;
      logic [level_delta_width-1:0] level;
   } stat_deltas_t;

   // one-hot, indexed by stat_ofs_*
   typedef struct packed {
      logic [num_stats-1:0] flags;
   } stat_commit_t;

   typedef struct packed {
      logic                      valid;
      logic                      write;
      logic [ram_addr_width-1:0] addr;
      logic [data_width-1:0]     wr_data;
   } host_req_t;

   typedef struct packed {
      logic [ram_addr_width-1:0] addr;
      logic                      wr_en;
      logic [data_width-1:0]     wr_data;
   } ram_port_t;

endpackage

// File: src/queue_stat_deltas.sv
// delta widths hold one sweep of events only; deltas must be committed every num_regs cycles
`timescale 1ns/1ps

module queue_stat_deltas import queue_regs_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  queue_event_t evt,
   input  logic         count_on_removed,
   input  stat_commit_t commit,
   output stat_deltas_t deltas
);

   logic                         len_evt;
   logic [count_delta_width-1:0] enq_inc;
   logic [count_delta_width-1:0] deq_inc;
   logic [word_delta_width-1:0]  word_inc;
   logic [byte_delta_width-1:0]  byte_inc;
   logic [level_delta_width-1:0] level_inc;
   stat_deltas_t                 base;

   // ----------------------------------------
   // this cycle's contribution
   // ----------------------------------------
   always_comb begin
      // rx counts lengths as packets leave, tx as they arrive
      len_evt  = count_on_removed ? evt.removed : evt.stored;
      enq_inc  = count_delta_width'(evt.stored);
      deq_inc  = count_delta_width'(evt.removed);
      word_inc = len_evt ? word_delta_width'(evt.word_cnt) : '0;
      byte_inc = len_evt ? byte_delta_width'(evt.byte_cnt) : '0;

      case ({evt.removed, evt.stored})
         2'b01: begin
            level_inc = level_delta_width'(1);
         end
         2'b10: begin
            // minus one
            level_inc = '1;
         end
         default: begin
            level_inc = '0;
         end
      endcase
   end

   // committed deltas restart from zero so this cycle's event is kept
   always_comb begin
      base = deltas;
      if (commit.flags[stat_ofs_enqueued]) begin
         base.enqueued = '0;
      end
      if (commit.flags[stat_ofs_dequeued]) begin
         base.dequeued = '0;
      end
      if (commit.flags[stat_ofs_words]) begin
         base.words = '0;
      end
      if (commit.flags[stat_ofs_bytes]) begin
         base.bytes = '0;
      end
      if (commit.flags[stat_ofs_level]) begin
         base.level = '0;
      end
   end

   // ----------------------------------------
   // delta registers
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         deltas <= '0;
      end else begin
         deltas.enqueued <= base.enqueued + enq_inc;
         deltas.dequeued <= base.dequeued + deq_inc;
         deltas.words    <= base.words + word_inc;
         deltas.bytes    <= base.bytes + byte_inc;
         deltas.level    <= base.level + level_inc;
      end
   end

endmodule

// File: src/stat_sweeper.sv
// host accesses during the post-reset clear are not stored; RAM owns one port, host wins
`timescale 1ns/1ps

module stat_sweeper import queue_regs_pkg::*; #(
   parameter int sweep_len = num_regs
) (
   input  logic                  clk,
   input  logic                  reset,
   input  host_req_t             host,
   input  logic [data_width-1:0] ram_rd_data,
   input  stat_deltas_t          rx_deltas,
   input  stat_deltas_t          tx_deltas,
   output ram_port_t             ram,
   output stat_commit_t          rx_commit,
   output stat_commit_t          tx_commit
);

   localparam logic [ram_addr_width-1:0] last_reg = ram_addr_width'(sweep_len - 1);

   typedef enum logic {
      st_clear,
      st_sweep
   } state_t;

   state_t                    state;
   state_t                    state_nxt;
   logic [ram_addr_width-1:0] reg_cnt;
   logic [ram_addr_width-1:0] reg_cnt_nxt;
   logic [data_width-1:0]     delta;

   // widen one delta; level is the only signed one
   function automatic logic [data_width-1:0] pick_delta(stat_deltas_t d, int ofs);
      case (ofs)
         stat_ofs_enqueued: return data_width'(d.enqueued);
         stat_ofs_dequeued: return data_width'(d.dequeued);
         stat_ofs_words:    return data_width'(d.words);
         stat_ofs_bytes:    return data_width'(d.bytes);
         stat_ofs_level:    return data_width'($signed(d.level));
         default:           return '0;
      endcase
   endfunction

   // ----------------------------------------
   // clear / sweep FSM
   // ----------------------------------------
   always_comb begin
      state_nxt   = state;
      reg_cnt_nxt = reg_cnt;
      ram         = '0;
      rx_commit   = '0;
      tx_commit   = '0;
      delta       = '0;

      case (state)
         st_clear: begin
            ram.addr  = reg_cnt;
            ram.wr_en = 1'b1;
            if (reg_cnt == last_reg) begin
               state_nxt   = st_sweep;
               reg_cnt_nxt = '0;
            end else begin
               reg_cnt_nxt = reg_cnt + 1'b1;
            end
         end

         default: begin
            if (host.valid) begin
               // sweep holds for the host cycle
               ram.addr    = host.addr;
               ram.wr_en   = host.write;
               ram.wr_data = host.wr_data;
            end else begin
               // ctrl_addr and unused slots fall through with a zero delta
               if (int'(reg_cnt) >= rx_base && int'(reg_cnt) < rx_base + num_stats) begin
                  delta = pick_delta(rx_deltas, int'(reg_cnt) - rx_base);
                  rx_commit.flags[int'(reg_cnt) - rx_base] = 1'b1;
               end else if (int'(reg_cnt) >= tx_base && int'(reg_cnt) < tx_base + num_stats) begin
                  delta = pick_delta(tx_deltas, int'(reg_cnt) - tx_base);
                  tx_commit.flags[int'(reg_cnt) - tx_base] = 1'b1;
               end

               ram.addr    = reg_cnt;
               ram.wr_en   = 1'b1;
               ram.wr_data = ram_rd_data + delta;
               reg_cnt_nxt = (reg_cnt == last_reg) ? '0 : reg_cnt + 1'b1;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= st_clear;
         reg_cnt <= '0;
      end else begin
         state   <= state_nxt;
         reg_cnt <= reg_cnt_nxt;
      end
   end

endmodule

// File: src/host_reg_access.sv
// host must drop req between requests; bad addresses read as dead_beef and ignore writes
`timescale 1ns/1ps

module host_reg_access import queue_regs_pkg::*; (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req,
   input  logic                      rd_wr_l,
   input  logic [reg_addr_width-1:0] addr,
   input  logic [data_width-1:0]     wr_data,
   input  logic [data_width-1:0]     ram_rd_data,
   output host_req_t                 host,
   output logic [data_width-1:0]     rd_data,
   output logic                      ack,
   output logic                      rx_queue_en,
   output logic                      tx_queue_en
);

   logic                      req_d1;
   logic                      new_req;
   logic                      addr_good;
   logic                      ctrl_wr;
   logic [ram_addr_width-1:0] word_addr;
   logic                      rx_disable;
   logic                      tx_disable;

   // ----------------------------------------
   // request decode
   // ----------------------------------------
   assign new_req   = req && !req_d1;
   assign word_addr = addr[ram_addr_width-1:0];
   assign addr_good = (addr[reg_addr_width-1:ram_addr_width] == '0) &&
                      (int'(word_addr) < num_regs);

   // any edge stalls the sweep, only good writes reach the RAM
   assign host.valid   = new_req;
   assign host.write   = new_req && addr_good && !rd_wr_l;
   assign host.addr    = word_addr;
   assign host.wr_data = wr_data;

   assign ctrl_wr = host.write && (int'(word_addr) == ctrl_addr);

   // disable bits, so enables come up high
   assign rx_queue_en = !rx_disable;
   assign tx_queue_en = !tx_disable;

   // ----------------------------------------
   // ack, read data, control copy
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         req_d1     <= 1'b0;
         ack        <= 1'b0;
         rd_data    <= '0;
         rx_disable <= 1'b0;
         tx_disable <= 1'b0;
      end else begin
         req_d1 <= req;
         ack    <= new_req;
         if (new_req) begin
            rd_data <= addr_good ? ram_rd_data : bad_addr_data;
         end
         if (ctrl_wr) begin
            rx_disable <= wr_data[rx_disable_bit];
            tx_disable <= wr_data[tx_disable_bit];
         end
      end
   end

endmodule

// File: src/stat_reg_ram.sv
// read is combinational; addresses at or above num_regs read undefined data
`timescale 1ns/1ps

module stat_reg_ram import queue_regs_pkg::*; (
   input  logic                  clk,
   input  ram_port_t             ram,
   output logic [data_width-1:0] rd_data
);

   logic [data_width-1:0] mem [num_regs];

   always_ff @(posedge clk) begin
      if (ram.wr_en) begin
         mem[ram.addr] <= ram.wr_data;
      end
   end

   // old value visible in the write cycle for read-modify-write
   assign rd_data = mem[ram.addr];

endmodule

// File: src/queue_regs_top.sv
// counters are exact only after 2*num_regs quiet cycles; one request in flight at a time
`timescale 1ns/1ps

module queue_regs_top import queue_regs_pkg::*; (
   input  logic                      clk,
   input  logic                      reset,

   // host port
   input  logic                      req,
   input  logic                      rd_wr_l,
   input  logic [reg_addr_width-1:0] addr,
   input  logic [data_width-1:0]     wr_data,
   output logic [data_width-1:0]     rd_data,
   output logic                      ack,

   // queues
   input  queue_event_t              rx_evt,
   input  queue_event_t              tx_evt,
   output logic                      rx_queue_en,
   output logic                      tx_queue_en
);

   stat_deltas_t          rx_deltas;
   stat_deltas_t          tx_deltas;
   stat_commit_t          rx_commit;
   stat_commit_t          tx_commit;
   host_req_t             host;
   ram_port_t             ram;
   logic [data_width-1:0] ram_rd_data;

   // ----------------------------------------
   // per-queue deltas
   // ----------------------------------------
   // rx lengths count as packets go to the CPU
   queue_stat_deltas i_rx_deltas (
      .clk              (clk),
      .reset            (reset),
      .evt              (rx_evt),
      .count_on_removed (1'b1),
      .commit           (rx_commit),
      .deltas           (rx_deltas)
   );

   // tx lengths count as the CPU pushes packets in
   queue_stat_deltas i_tx_deltas (
      .clk              (clk),
      .reset            (reset),
      .evt              (tx_evt),
      .count_on_removed (1'b0),
      .commit           (tx_commit),
      .deltas           (tx_deltas)
   );

   // ----------------------------------------
   // sweep, host and RAM
   // ----------------------------------------
   stat_sweeper #(
      .sweep_len (num_regs)
   ) i_sweeper (
      .clk         (clk),
      .reset       (reset),
      .host        (host),
      .ram_rd_data (ram_rd_data),
      .rx_deltas   (rx_deltas),
      .tx_deltas   (tx_deltas),
      .ram         (ram),
      .rx_commit   (rx_commit),
      .tx_commit   (tx_commit)
   );

   host_reg_access i_host (
      .clk         (clk),
      .reset       (reset),
      .req         (req),
      .rd_wr_l     (rd_wr_l),
      .addr        (addr),
      .wr_data     (wr_data),
      .ram_rd_data (ram_rd_data),
      .host        (host),
      .rd_data     (rd_data),
      .ack         (ack),
      .rx_queue_en (rx_queue_en),
      .tx_queue_en (tx_queue_en)
   );

   stat_reg_ram i_ram (
      .clk     (clk),
      .ram     (ram),
      .rd_data (ram_rd_data)
   );

endmodule

// File: tests/queue_regs_asserts.sv
// bound into host_reg_access; a request edge is a rise of req as sampled on clk
`timescale 1ns/1ps

module queue_regs_asserts import queue_regs_pkg::*; (
   input logic                      clk,
   input logic                      reset,
   input logic                      req,
   input logic                      rd_wr_l,
   input logic [reg_addr_width-1:0] addr,
   input logic [data_width-1:0]     wr_data,
   input logic                      ack,
   input logic                      rx_queue_en,
   input logic                      tx_queue_en
);

   // ----------------------------------------
   // handshake
   // ----------------------------------------
   a_ack_after_edge: assert property (@(posedge clk) disable iff (reset)
      $rose(req) |=> ack)
      else $error("ack missing one cycle after request edge");

   a_ack_only_after_edge: assert property (@(posedge clk) disable iff (reset)
      !$rose(req) |=> !ack)
      else $error("ack without a request edge");

   a_ack_single: assert property (@(posedge clk) disable iff (reset)
      ack |=> !ack)
      else $error("ack high two cycles in a row");

   a_ack_reset: assert property (@(posedge clk)
      reset |=> !ack)
      else $error("ack high after a reset cycle");

   // ----------------------------------------
   // enables follow control writes only
   // ----------------------------------------
   a_ctrl_write: assert property (@(posedge clk) disable iff (reset)
      ($rose(req) && !rd_wr_l && addr == reg_addr_width'(ctrl_addr)) |=>
      (rx_queue_en == !$past(wr_data[rx_disable_bit]) &&
       tx_queue_en == !$past(wr_data[tx_disable_bit])))
      else $error("queue enables do not match written control bits");

   a_enables_hold: assert property (@(posedge clk) disable iff (reset)
      !($rose(req) && !rd_wr_l && addr == reg_addr_width'(ctrl_addr)) |=>
      $stable({rx_queue_en, tx_queue_en}))
      else $error("queue enables changed without a control write");

endmodule

bind host_reg_access queue_regs_asserts i_asserts (
   .clk         (clk),
   .reset       (reset),
   .req         (req),
   .rd_wr_l     (rd_wr_l),
   .addr        (addr),
   .wr_data     (wr_data),
   .ack         (ack),
   .rx_queue_en (rx_queue_en),
   .tx_queue_en (tx_queue_en)
);

// File: tests/tb_checker.sv
// counters are compared only after 2*num_regs quiet cycles; counter writes need settled deltas
`timescale 1ns/1ps

module tb_checker import queue_regs_pkg::*; (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      req,
   input  logic                      rd_wr_l,
   input  logic [reg_addr_width-1:0] addr,
   input  logic [data_width-1:0]     wr_data,
   input  logic [data_width-1:0]     rd_data,
   input  logic                      ack,
   input  logic                      rx_queue_en,
   input  logic                      tx_queue_en,
   input  queue_event_t              rx_evt,
   input  queue_event_t              tx_evt,
   output int                        errors,
   output int                        reads
);

   localparam int settle_cycles = 2 * num_regs;

   logic [data_width-1:0]     model [num_regs];
   logic                      req_q;
   logic                      pend;
   logic                      pend_chk;
   logic [reg_addr_width-1:0] pend_addr;
   logic [data_width-1:0]     pend_exp;
   int                        quiet;

   // rx counts lengths on removed, tx on stored
   task automatic add_events(queue_event_t e, int base, bit len_on_removed);
      logic len_evt;
      len_evt = len_on_removed ? e.removed : e.stored;
      model[base + stat_ofs_enqueued] = model[base + stat_ofs_enqueued] + 32'(e.stored);
      model[base + stat_ofs_dequeued] = model[base + stat_ofs_dequeued] + 32'(e.removed);
      if (len_evt) begin
         model[base + stat_ofs_words] = model[base + stat_ofs_words] + 32'(e.word_cnt);
         model[base + stat_ofs_bytes] = model[base + stat_ofs_bytes] + 32'(e.byte_cnt);
      end
      if (e.stored && !e.removed) begin
         model[base + stat_ofs_level] = model[base + stat_ofs_level] + 32'd1;
      end else if (e.removed && !e.stored) begin
         model[base + stat_ofs_level] = model[base + stat_ofs_level] - 32'd1;
      end
   endtask

   always @(posedge clk) begin
      logic new_req;
      logic good;
      new_req = req && !req_q;
      good    = int'(addr) < num_regs;
      if (reset) begin
         foreach (model[i]) model[i] = '0;
         req_q = 1'b0;
         pend  = 1'b0;
         quiet = 0;
      end else begin
         // --------------------------------
         // ack and read data of the last edge
         // --------------------------------
         if (pend) begin
            if (!ack) begin
               $display("ERROR: no ack one cycle after request at address 0x%02h", pend_addr);
               errors++;
            end else if (pend_chk) begin
               reads++;
               if (rd_data !== pend_exp) begin
                  $display("CHECK FAILED rd_data at addr 0x%02h: got 0x%08h, expected 0x%08h",
                           pend_addr, rd_data, pend_exp);
                  errors++;
               end
            end
         end else if (ack) begin
            $display("ERROR: ack seen without a request edge one cycle before");
            errors++;
         end

         if (rx_queue_en !== !model[ctrl_addr][rx_disable_bit]) begin
            $display("CHECK FAILED rx_queue_en: got 0x%h, expected 0x%h",
                     rx_queue_en, !model[ctrl_addr][rx_disable_bit]);
            errors++;
         end
         if (tx_queue_en !== !model[ctrl_addr][tx_disable_bit]) begin
            $display("CHECK FAILED tx_queue_en: got 0x%h, expected 0x%h",
                     tx_queue_en, !model[ctrl_addr][tx_disable_bit]);
            errors++;
         end

         // new request, expected value taken before this cycle's events
         pend     = new_req;
         pend_chk = 1'b0;
         if (new_req) begin
            pend_addr = addr;
            if (rd_wr_l) begin
               if (!good) begin
                  pend_exp = bad_addr_data;
                  pend_chk = 1'b1;
               end else if (int'(addr) == ctrl_addr || quiet >= settle_cycles) begin
                  pend_exp = model[addr[ram_addr_width-1:0]];
                  pend_chk = 1'b1;
               end
            end else if (good) begin
               model[addr[ram_addr_width-1:0]] = wr_data;
            end
         end

         add_events(rx_evt, rx_base, 1'b1);
         add_events(tx_evt, tx_base, 1'b0);

         // host edges stall the sweep, so they do not count as quiet
         if (rx_evt.stored || rx_evt.removed || tx_evt.stored || tx_evt.removed) begin
            quiet = 0;
         end else if (!new_req) begin
            quiet++;
         end
         req_q = req;
      end
   end

endmodule

// File: tests/tb_top.sv
// inputs change 1 ns after the rising edge; counters are only read after 2*num_regs idle cycles
`timescale 1ns/1ps

module tb_top import queue_regs_pkg::*; ();

   localparam int ack_timeout = 8;

   typedef struct {
      string                     name;
      int                        rx_st;
      int                        rx_rm;
      int                        tx_st;
      int                        tx_rm;
      int                        word_max;
      int                        byte_max;
      bit                        overlap;
      bit                        wr_en;
      logic [reg_addr_width-1:0] wr_addr;
      logic [data_width-1:0]     wr_data;
      bit                        reset_after_wr;
      logic [reg_addr_width-1:0] rd_first;
      logic [reg_addr_width-1:0] rd_last;
      logic [reg_addr_width-1:0] rd_extra;
   } test_row_t;

   logic                      clk;
   logic                      reset;
   logic                      req;
   logic                      rd_wr_l;
   logic [reg_addr_width-1:0] addr;
   logic [data_width-1:0]     wr_data;
   logic [data_width-1:0]     rd_data;
   logic                      ack;
   logic                      rx_queue_en;
   logic                      tx_queue_en;
   queue_event_t              rx_evt;
   queue_event_t              tx_evt;
   int                        chk_errors;
   int                        chk_reads;
   int                        tb_errors;
   test_row_t                 rows[$];

   queue_regs_top i_dut (
      .clk         (clk),
      .reset       (reset),
      .req         (req),
      .rd_wr_l     (rd_wr_l),
      .addr        (addr),
      .wr_data     (wr_data),
      .rd_data     (rd_data),
      .ack         (ack),
      .rx_evt      (rx_evt),
      .tx_evt      (tx_evt),
      .rx_queue_en (rx_queue_en),
      .tx_queue_en (tx_queue_en)
   );

   tb_checker i_checker (
      .clk         (clk),
      .reset       (reset),
      .req         (req),
      .rd_wr_l     (rd_wr_l),
      .addr        (addr),
      .wr_data     (wr_data),
      .rd_data     (rd_data),
      .ack         (ack),
      .rx_queue_en (rx_queue_en),
      .tx_queue_en (tx_queue_en),
      .rx_evt      (rx_evt),
      .tx_evt      (tx_evt),
      .errors      (chk_errors),
      .reads       (chk_reads)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ----------------------------------------
   // helpers
   // ----------------------------------------
   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   // same length as the reset at the start of the run
   task automatic pulse_reset();
      reset = 1'b1;
      repeat (10) next_cycle();
      reset = 1'b0;
   endtask

   // counts drawn from 1..max
   function automatic queue_event_t make_event(bit st, bit rm, int word_max, int byte_max);
      queue_event_t e;
      e.stored   = st;
      e.removed  = rm;
      e.word_cnt = word_cnt_width'(1 + $urandom % word_max);
      e.byte_cnt = byte_cnt_width'(1 + $urandom % byte_max);
      return e;
   endfunction

   task automatic apply_events(test_row_t row);
      int n;
      n = row.rx_st;
      if (row.rx_rm > n) n = row.rx_rm;
      if (row.tx_st > n) n = row.tx_st;
      if (row.tx_rm > n) n = row.tx_rm;
      for (int i = 0; i < n; i++) begin
         rx_evt = make_event(i < row.rx_st, i < row.rx_rm, row.word_max, row.byte_max);
         tx_evt = make_event(i < row.tx_st, i < row.tx_rm, row.word_max, row.byte_max);
         next_cycle();
      end
      rx_evt = '0;
      tx_evt = '0;
   endtask

   task automatic host_access(bit is_read, logic [reg_addr_width-1:0] a,
                              logic [data_width-1:0] d);
      int waited;
      req     = 1'b1;
      rd_wr_l = is_read;
      addr    = a;
      wr_data = d;
      waited  = 0;
      do begin
         next_cycle();
         waited++;
      end while (!ack && waited < ack_timeout);
      if (!ack) begin
         $display("ERROR: host access at address 0x%02h got no ack in %0d cycles", a, waited);
         tb_errors++;
      end
      req = 1'b0;
      // req must be seen low before the next edge
      next_cycle();
   endtask

   task automatic read_back(test_row_t row);
      for (int a = int'(row.rd_first); a <= int'(row.rd_last); a++) begin
         host_access(1'b1, reg_addr_width'(a), '0);
      end
      if (row.rd_extra != '0) begin
         host_access(1'b1, row.rd_extra, '0);
      end
   endtask

   function automatic test_row_t make_row(string name, int rx_st, int rx_rm, int tx_st,
                                          int tx_rm, int word_max, int byte_max, bit overlap,
                                          bit wr_en, logic [7:0] wr_addr, logic [31:0] wr_data,
                                          bit reset_after_wr, logic [7:0] rd_first,
                                          logic [7:0] rd_last, logic [7:0] rd_extra);
      test_row_t r;
      r.name           = name;
      r.rx_st          = rx_st;
      r.rx_rm          = rx_rm;
      r.tx_st          = tx_st;
      r.tx_rm          = tx_rm;
      r.word_max       = word_max;
      r.byte_max       = byte_max;
      r.overlap        = overlap;
      r.wr_en          = wr_en;
      r.wr_addr        = wr_addr;
      r.wr_data        = wr_data;
      r.reset_after_wr = reset_after_wr;
      r.rd_first       = rd_first;
      r.rd_last        = rd_last;
      r.rd_extra       = rd_extra;
      return r;
   endfunction

   // ----------------------------------------
   // stimulus table
   // ----------------------------------------
   // name, rx st/rm, tx st/rm, word/byte max, overlap, write en/addr/data,
   // reset after the write, reads first/last/extra
   task automatic build_table();
      rows.push_back(make_row("burst", 20, 12, 15, 18, 1023, 4095, 0, 0, 8'h00, 32'h0,
                              0, 8'd0, 8'd10, 8'h00));
      rows.push_back(make_row("rx_negative_level", 2, 14, 3, 1, 1023, 4095, 0, 0, 8'h00, 32'h0,
                              0, 8'd1, 8'd10, 8'h00));
      rows.push_back(make_row("events_during_reads", 30, 25, 28, 28, 500, 2000, 1, 0, 8'h00,
                              32'h0, 0, 8'd1, 8'd10, 8'h00));
      rows.push_back(make_row("ctrl_disable_both", 5, 5, 5, 5, 64, 256, 0, 1, 8'h00, 32'h3,
                              0, 8'd0, 8'd0, 8'h00));
      rows.push_back(make_row("ctrl_disable_rx", 0, 0, 0, 0, 1, 1, 0, 1, 8'h00, 32'h1,
                              0, 8'd0, 8'd0, 8'h00));
      rows.push_back(make_row("ctrl_enable", 0, 0, 0, 0, 1, 1, 0, 1, 8'h00, 32'h0,
                              0, 8'd0, 8'd0, 8'h00));
      rows.push_back(make_row("write_rx_bytes", 6, 6, 3, 3, 1023, 4095, 0, 1, 8'h04,
                              32'h1234_0000, 0, 8'd1, 8'd10, 8'h00));
      rows.push_back(make_row("write_tx_level", 0, 0, 2, 7, 100, 1500, 0, 1, 8'h0a,
                              32'hffff_fff0, 0, 8'd6, 8'd10, 8'h00));
      rows.push_back(make_row("bad_addr_num_regs", 0, 0, 0, 0, 1, 1, 0, 1, 8'h0b,
                              32'hffff_ffff, 0, 8'd0, 8'd12, 8'h31));
      rows.push_back(make_row("bad_addr_upper", 0, 0, 0, 0, 1, 1, 0, 1, 8'h31,
                              32'h5555_5555, 0, 8'd0, 8'd10, 8'hf0));
      // counters and control are nonzero here, so the clear has something to wipe
      rows.push_back(make_row("reset_clear", 0, 0, 0, 0, 1, 1, 0, 1, 8'h00, 32'h3,
                              1, 8'd0, 8'd10, 8'h00));
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      int errs_before;
      int total;
      test_row_t row;

      void'($urandom(32'h8ab79414));
      reset     = 1'b1;
      req       = 1'b0;
      rd_wr_l   = 1'b1;
      addr      = '0;
      wr_data   = '0;
      rx_evt    = '0;
      tx_evt    = '0;
      tb_errors = 0;
      build_table();

      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;

      foreach (rows[i]) begin
         row         = rows[i];
         errs_before = chk_errors + tb_errors;
         if (row.wr_en) begin
            host_access(1'b0, row.wr_addr, row.wr_data);
         end
         if (row.reset_after_wr) begin
            pulse_reset();
         end
         if (row.overlap) begin
            fork
               apply_events(row);
               read_back(row);
            join
         end else begin
            apply_events(row);
         end
         repeat (2 * num_regs) next_cycle();
         read_back(row);
         $display("test %0d %s: %0d errors", i, row.name, chk_errors + tb_errors - errs_before);
      end

      repeat (4) next_cycle();
      total = chk_errors + tb_errors;
      $display("%0d tests, %0d reads checked, %0d errors", rows.size(), chk_reads, total);
      if (total == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// File: tb.f
src/queue_regs_pkg.sv
src/queue_stat_deltas.sv
src/stat_sweeper.sv
src/host_reg_access.sv
src/stat_reg_ram.sv
src/queue_regs_top.sv
tests/queue_regs_asserts.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: Makefile
# Verilator build and run of the queue register block testbench

VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
